// File: Bender.yml
package:
  name: gb_ctrl

sources:
  - files:
      - verilog/gb_ctrl_pkg.sv
      - verilog/download_decoder.sv
      - verilog/palette_store.sv
      - verilog/cheat_loader.sv
      - verilog/ff_control.sv
      - verilog/backup_sequencer.sv
      - verilog/backup_port.sv
      - verilog/gb_ctrl_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_gb_ctrl.sv

// File: compile.f
+incdir+test
verilog/gb_ctrl_pkg.sv
verilog/download_decoder.sv
verilog/palette_store.sv
verilog/cheat_loader.sv
verilog/ff_control.sv
verilog/backup_sequencer.sv
verilog/backup_port.sv
verilog/gb_ctrl_top.sv
test/tb_gb_ctrl.sv

// File: test/tb_gb_ctrl_ref.svh
`ifndef TB_GB_CTRL_REF_SVH
`define TB_GB_CTRL_REF_SVH

// Fibonacci LFSR, taps 32 22 2 1
logic [31:0] lfsr_state = 32'h2cf6_299a;

function automatic logic lfsr_bit();
	logic b;
	b = lfsr_state[31];
	lfsr_state = {lfsr_state[30:0],
		lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
	return b;
endfunction

function automatic logic [15:0] rand_word();
	logic [15:0] w;
	w = '0;
	for (int i = 0; i < 16; i++)
		w = {w[14:0], lfsr_bit()};
	return w;
endfunction

// Cart RAM contents, every address bit shows up in the word
function automatic logic [15:0] ram_word(input logic [16:0] a);
	return a[15:0] ^ {a[7:0], a[15:8]} ^ {15'd0, a[16]} ^ 16'h3c5a;
endfunction

// Palette register after one download word, bytes swapped on the way in
function automatic logic [127:0] ref_palette_shift(input logic [127:0] p, input logic [15:0] w);
	return (p << 16) | {112'd0, w[7:0], w[15:8]};
endfunction

// Eight words, word 0 in the low bits, low half of each field first
function automatic gb_ctrl_pkg::cheat_code_t ref_cheat(input logic [127:0] words);
	gb_ctrl_pkg::cheat_code_t c;
	c.flags   = {words[31:16], words[15:0]};
	c.address = {words[63:48], words[47:32]};
	c.compare = {words[95:80], words[79:64]};
	c.replace = {words[127:112], words[111:96]};
	return c;
endfunction

function automatic int ref_block_count(input logic [7:0] mask, input logic rtc_on);
	return int'(mask) + 1 + (rtc_on ? 1 : 0);
endfunction

function automatic logic ref_is_rtc(input logic [7:0] lba_low, input logic [7:0] mask,
		input logic rtc_on);
	return rtc_on && (int'(lba_low) == int'(mask) + 1);
endfunction

// Word the host reads back from the SD buffer
function automatic logic [15:0] ref_buff_din(input logic is_rtc, input logic [7:0] lba_low,
		input logic [7:0] w, input gb_ctrl_pkg::rtc_words_t r);
	if (!is_rtc)
		return ram_word({lba_low, w});
	if (w == 8'd0)
		return r.timestamp[15:0];
	if (w == 8'd1)
		return r.timestamp[31:16];
	if (w == 8'd2)
		return r.savedtime[15:0];
	if (w == 8'd3)
		return r.savedtime[31:16];
	return 16'hffff;
endfunction

`endif

// File: test/tb_gb_ctrl.sv
`timescale 1ns/1ps

module tb_gb_ctrl;

	localparam int NUM_PAL_WORDS = 10;
	localparam int BLOCK_WORDS   = 6;
	localparam int WAIT_LIMIT    = 300;

	logic                     clk_sys = 1'b0;
	logic                     reset;
	gb_ctrl_pkg::dl_bus_t     dl;
	logic [7:0]               dl_index;
	logic                     img_mounted;
	logic                     img_readonly;
	logic                     img_size_nz;
	logic                     bk_load_cmd;
	logic                     bk_save_cmd;
	logic                     autosave;
	logic                     osd_open;
	logic                     cram_wr;
	logic                     has_save;
	logic [7:0]               ram_mask;
	logic                     rtc_inuse;
	gb_ctrl_pkg::rtc_words_t  rtc;
	gb_ctrl_pkg::dl_word_t    bk_q;
	logic                     sd_ack;
	gb_ctrl_pkg::buff_addr_t  sd_buff_addr;
	gb_ctrl_pkg::dl_word_t    sd_buff_dout;
	logic                     sd_buff_wr;
	logic                     ff_button;
	logic                     ff_mute_en;
	logic [15:0]              audio_l;
	logic [15:0]              audio_r;
	gb_ctrl_pkg::palette_t    palette;
	gb_ctrl_pkg::cheat_code_t code;
	logic                     code_valid;
	logic                     fast_forward;
	logic [15:0]              audio_l_out;
	logic [15:0]              audio_r_out;
	gb_ctrl_pkg::sd_req_t     sd;
	gb_ctrl_pkg::bk_bus_t     bk;
	logic                     rtc_wr;
	gb_ctrl_pkg::dl_word_t    sd_buff_din;
	logic                     busy;
	logic                     led_user;

	int           errors      = 0;
	int           checks      = 0;
	int           timeouts    = 0;
	int           valid_count = 0;
	string        name_q[$];
	logic [127:0] exp_q[$];
	logic [127:0] act_q[$];
	logic [31:0]  blk_lba_q[$];
	logic         blk_rd_q[$];
	logic         blk_wr_q[$];
	event         run_end;

	`include "tb_gb_ctrl_ref.svh"

	gb_ctrl_top #(
		.ff_hold_cycles (40)
	) i_gb_ctrl_top (
		.clk_sys (clk_sys), .reset (reset), .dl (dl), .dl_index (dl_index),
		.img_mounted (img_mounted), .img_readonly (img_readonly),
		.img_size_nz (img_size_nz), .bk_load_cmd (bk_load_cmd),
		.bk_save_cmd (bk_save_cmd), .autosave (autosave), .osd_open (osd_open),
		.cram_wr (cram_wr), .has_save (has_save), .ram_mask (ram_mask),
		.rtc_inuse (rtc_inuse), .rtc (rtc), .bk_q (bk_q), .sd_ack (sd_ack),
		.sd_buff_addr (sd_buff_addr), .sd_buff_dout (sd_buff_dout),
		.sd_buff_wr (sd_buff_wr), .ff_button (ff_button), .ff_mute_en (ff_mute_en),
		.audio_l (audio_l), .audio_r (audio_r), .palette (palette), .code (code),
		.code_valid (code_valid), .fast_forward (fast_forward),
		.audio_l_out (audio_l_out), .audio_r_out (audio_r_out), .sd (sd), .bk (bk),
		.rtc_wr (rtc_wr), .sd_buff_din (sd_buff_din), .busy (busy),
		.led_user (led_user)
	);

	always #4 clk_sys = ~clk_sys;

	// Cart RAM read port
	assign bk_q = ram_word(bk.addr);

	always @(negedge clk_sys) begin
		if (code_valid)
			valid_count++;
	end

	////////////////////////////////////////
	// Checking
	////////////////////////////////////////

	task automatic expect_value(input string name, input logic [127:0] exp,
			input logic [127:0] act);
		name_q.push_back(name);
		exp_q.push_back(exp);
		act_q.push_back(act);
	endtask

	initial begin : compare_proc
		string        name;
		logic [127:0] exp;
		logic [127:0] act;
		forever begin
			@(negedge clk_sys);
			while (exp_q.size() > 0) begin
				name = name_q.pop_front();
				exp  = exp_q.pop_front();
				act  = act_q.pop_front();
				checks++;
				assert (act === exp) else begin
					errors++;
					$display("CHECK FAILED %s: expected %0h, actual %0h", name, exp, act);
				end
			end
		end
	end

	task automatic report_timeout(input string what);
		timeouts++;
		$display("Timeout while waiting for %s", what);
		-> run_end;
	endtask

	task automatic wait_busy(input logic level, input string what);
		int n;
		n = 0;
		while (busy !== level && n < WAIT_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (busy !== level)
			report_timeout(what);
	endtask

	task automatic wait_code_valid();
		int n;
		n = 0;
		while (code_valid !== 1'b1 && n < WAIT_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (code_valid !== 1'b1)
			report_timeout("cheat code valid");
	endtask

	task automatic drain_compares();
		int n;
		n = 0;
		while (exp_q.size() > 0 && n < WAIT_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (exp_q.size() > 0)
			report_timeout("pending comparisons");
	endtask

	// Block numbers and directions seen by the SD host
	task automatic check_blocks(input string name, input logic rd);
		int i;
		expect_value($sformatf("%s block count", name),
			ref_block_count(ram_mask, rtc_inuse), blk_lba_q.size());
		i = 0;
		while (blk_lba_q.size() > 0) begin
			expect_value($sformatf("%s lba %0d", name, i), i, blk_lba_q.pop_front());
			expect_value($sformatf("%s rd %0d", name, i), rd, blk_rd_q.pop_front());
			expect_value($sformatf("%s wr %0d", name, i), !rd, blk_wr_q.pop_front());
			i++;
		end
	endtask

	task automatic check_word(input logic [31:0] lba, input logic is_rd, input logic is_rtc,
			input int w, input logic [15:0] dout);
		if (is_rd) begin
			expect_value("load bk wr", !is_rtc, bk.wr);
			expect_value("load rtc wr", is_rtc, rtc_wr);
			if (!is_rtc) begin
				expect_value("load bk addr", {lba[7:0], 8'(w)}, bk.addr);
				expect_value("load bk data", dout, bk.data);
			end
		end else begin
			expect_value($sformatf("save din lba %0d word %0d", lba, w),
				ref_buff_din(is_rtc, lba[7:0], 8'(w), rtc), sd_buff_din);
			expect_value("save bk wr", 1'b0, bk.wr);
		end
	endtask

	////////////////////////////////////////
	// SD host model
	////////////////////////////////////////

	initial begin : sd_host
		logic [31:0] lba;
		logic [15:0] dout;
		logic        is_rd;
		logic        is_rtc;
		forever begin
			@(negedge clk_sys);
			if (!reset && (sd.rd || sd.wr)) begin
				lba    = sd.lba;
				is_rd  = sd.rd;
				is_rtc = ref_is_rtc(lba[7:0], ram_mask, rtc_inuse);
				blk_lba_q.push_back(lba);
				blk_rd_q.push_back(sd.rd);
				blk_wr_q.push_back(sd.wr);
				sd_ack = 1'b1;
				// Host moves one buffer word per cycle and checks it a cycle later
				for (int w = 0; w <= BLOCK_WORDS; w++) begin
					if (w > 0) begin
						@(negedge clk_sys);
						check_word(lba, is_rd, is_rtc, w - 1, dout);
					end
					if (w < BLOCK_WORDS) begin
						dout         = rand_word();
						sd_buff_addr = 8'(w);
						sd_buff_dout = dout;
						sd_buff_wr   = is_rd;
					end else begin
						sd_buff_wr = 1'b0;
					end
				end
				expect_value("request dropped", 2'b00, {sd.rd, sd.wr});
				sd_ack = 1'b0;
			end
		end
	end

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	initial begin : stimulus
		logic [127:0] exp_pal;
		logic [127:0] cheat_words;
		logic [15:0]  word;
		reset        = 1'b1;
		dl           = '0;
		dl_index     = 8'h00;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		img_size_nz  = 1'b0;
		bk_load_cmd  = 1'b0;
		bk_save_cmd  = 1'b0;
		autosave     = 1'b0;
		osd_open     = 1'b0;
		cram_wr      = 1'b0;
		has_save     = 1'b1;
		ram_mask     = 8'd3;
		rtc_inuse    = 1'b1;
		sd_ack       = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr   = 1'b0;
		ff_button    = 1'b0;
		ff_mute_en   = 1'b1;
		rtc.timestamp[15:0]  = rand_word();
		rtc.timestamp[31:16] = rand_word();
		rtc.savedtime[15:0]  = rand_word();
		rtc.savedtime[31:16] = rand_word();
		audio_l = rand_word() | 16'h0001;
		audio_r = rand_word() | 16'h0001;
		repeat (10) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);

		exp_pal = gb_ctrl_pkg::PALETTE_DEFAULT;
		expect_value("reset palette", exp_pal[127:32], palette);
		expect_value("reset sd rd wr", 2'b00, {sd.rd, sd.wr});
		expect_value("reset busy", 1'b0, busy);
		expect_value("reset code valid", 1'b0, code_valid);
		expect_value("reset fast forward", 1'b0, fast_forward);
		expect_value("reset bk wr rtc wr", 2'b00, {bk.wr, rtc_wr});
		expect_value("reset led", 1'b0, led_user);

		// Palette download
		dl_index  = gb_ctrl_pkg::FT_PALETTE;
		dl.active = 1'b1;
		for (int i = 0; i < NUM_PAL_WORDS; i++) begin
			@(negedge clk_sys);
			word    = rand_word();
			dl.wr   = 1'b1;
			dl.addr = 25'(2 * i);
			dl.data = word;
			exp_pal = ref_palette_shift(exp_pal, word);
		end
		@(negedge clk_sys);
		dl.wr = 1'b0;
		@(negedge clk_sys);
		expect_value("palette", exp_pal[127:32], palette);
		expect_value("led during download", 1'b1, led_user);
		dl.active = 1'b0;

		// Cheat download of one code in eight words
		@(negedge clk_sys);
		valid_count = 0;
		dl_index    = gb_ctrl_pkg::FT_CHEAT;
		dl.active   = 1'b1;
		for (int i = 0; i < 8; i++) begin
			@(negedge clk_sys);
			word                   = rand_word();
			cheat_words[16*i +: 16] = word;
			dl.wr                  = 1'b1;
			dl.addr                = 25'(2 * i);
			dl.data                = word;
		end
		@(negedge clk_sys);
		dl.wr = 1'b0;
		wait_code_valid();
		expect_value("cheat code", ref_cheat(cheat_words), code);
		repeat (4) @(negedge clk_sys);
		expect_value("cheat valid pulses", 1, valid_count);
		dl.active = 1'b0;

		// Cart download with a writable save image mounted during it
		@(negedge clk_sys);
		img_size_nz = 1'b1;
		dl_index    = gb_ctrl_pkg::FT_CART_GB;
		dl.active   = 1'b1;
		repeat (3) @(negedge clk_sys);
		img_mounted = 1'b1;
		@(negedge clk_sys);
		img_mounted = 1'b0;
		repeat (3) @(negedge clk_sys);
		dl.active = 1'b0;
		wait_busy(1'b1, "backup load start");
		wait_busy(1'b0, "backup load end");
		check_blocks("load", 1'b1);

		// Cart RAM write with the menu closed leaves a save pending
		cram_wr = 1'b1;
		@(negedge clk_sys);
		cram_wr = 1'b0;
		@(negedge clk_sys);
		expect_value("led with pending save", 1'b1, led_user);

		// Save on command
		bk_save_cmd = 1'b1;
		wait_busy(1'b1, "backup save start");
		bk_save_cmd = 1'b0;
		wait_busy(1'b0, "backup save end");
		check_blocks("save", 1'b0);
		expect_value("led after save", 1'b0, led_user);

		// Short tap latches fast forward
		@(negedge clk_sys);
		ff_button = 1'b1;
		repeat (5) @(negedge clk_sys);
		ff_button = 1'b0;
		repeat (6) @(negedge clk_sys);
		expect_value("ff after tap", 1'b1, fast_forward);
		expect_value("muted left", 16'd0, audio_l_out);
		expect_value("muted right", 16'd0, audio_r_out);

		// Long hold only runs while held
		ff_button = 1'b1;
		repeat (60) @(negedge clk_sys);
		expect_value("ff while held", 1'b1, fast_forward);
		ff_button = 1'b0;
		repeat (6) @(negedge clk_sys);
		expect_value("ff after hold", 1'b0, fast_forward);
		expect_value("audio left after hold", audio_l, audio_l_out);

		// Button is masked while a download runs
		dl_index  = 8'h00;
		dl.active = 1'b1;
		@(negedge clk_sys);
		ff_button = 1'b1;
		repeat (5) @(negedge clk_sys);
		expect_value("ff during download", 1'b0, fast_forward);
		ff_button = 1'b0;
		repeat (6) @(negedge clk_sys);
		expect_value("ff after download press", 1'b0, fast_forward);
		dl.active = 1'b0;

		drain_compares();
		-> run_end;
	end

	initial begin : run_control
		@(run_end);
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// File: verilog/backup_port.sv
`timescale 1ns/1ps

module backup_port (
	input  gb_ctrl_pkg::block_kind_e kind,
	input  logic [7:0]               lba_low,
	input  logic                     sd_ack,
	input  gb_ctrl_pkg::buff_addr_t  sd_buff_addr,
	input  gb_ctrl_pkg::dl_word_t    sd_buff_dout,
	input  logic                     sd_buff_wr,
	input  gb_ctrl_pkg::dl_word_t    bk_q,
	input  gb_ctrl_pkg::rtc_words_t  rtc,
	output gb_ctrl_pkg::bk_bus_t     bk,
	output logic                     rtc_wr,
	output gb_ctrl_pkg::dl_word_t    sd_buff_din
);

	logic buff_wr;

	// Buffer writes only count while the host acknowledges the block
	assign buff_wr = sd_buff_wr & sd_ack;

	////////////////////////////////////////
	// Write path
	////////////////////////////////////////

	assign bk.addr = {1'b0, lba_low, sd_buff_addr};
	assign bk.data = sd_buff_dout;
	assign bk.wr   = buff_wr & (kind == gb_ctrl_pkg::BLK_RAM);
	assign rtc_wr  = buff_wr & (kind == gb_ctrl_pkg::BLK_RTC);

	////////////////////////////////////////
	// Read-back path
	////////////////////////////////////////

	always_comb begin
		if (kind == gb_ctrl_pkg::BLK_RAM) begin
			sd_buff_din = bk_q;
		end else begin
			// Only the first 8 bytes of the RTC block carry data
			case (sd_buff_addr)
				8'd0:    sd_buff_din = rtc.timestamp[15:0];
				8'd1:    sd_buff_din = rtc.timestamp[31:16];
				8'd2:    sd_buff_din = rtc.savedtime[15:0];
				8'd3:    sd_buff_din = rtc.savedtime[31:16];
				default: sd_buff_din = gb_ctrl_pkg::RTC_FILL;
			endcase
		end
	end

endmodule

// File: verilog/backup_sequencer.sv
`timescale 1ns/1ps

module backup_sequencer (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     cart_done,
	input  logic                     save_enabled,
	input  logic                     has_save,
	input  logic                     img_size_nz,
	input  logic                     bk_load_cmd,
	input  logic                     bk_save_cmd,
	input  logic                     autosave,
	input  logic                     osd_open,
	input  logic                     cram_wr,
	input  logic [7:0]               ram_mask,
	input  logic                     rtc_inuse,
	input  logic                     sd_ack,
	output gb_ctrl_pkg::sd_req_t     sd,
	output gb_ctrl_pkg::block_kind_e kind,
	output logic                     busy,
	output logic                     save_pending
);

	gb_ctrl_pkg::backup_state_e state;
	gb_ctrl_pkg::sd_req_t       sd_q;

	logic loading;
	logic ack_q;
	logic load_q;
	logic save_q;
	logic load_edge;
	logic save_edge;
	logic save_req;
	logic load_start;
	logic save_start;
	logic last_block;

	// Autosave fires when the menu opens over unsaved cart RAM
	assign save_req   = bk_save_cmd | (save_pending & osd_open & autosave);
	assign load_start = save_enabled & (load_edge | (cart_done & img_size_nz));
	assign save_start = save_enabled & save_edge;

	// With RTC in use one extra block follows the last RAM block
	assign last_block = rtc_inuse ? (sd_q.lba[7:0] > ram_mask) : (sd_q.lba[7:0] >= ram_mask);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			load_q       <= 1'b0;
			save_q       <= 1'b0;
			load_edge    <= 1'b0;
			save_edge    <= 1'b0;
			ack_q        <= 1'b0;
			save_pending <= 1'b0;
		end else begin
			load_q    <= bk_load_cmd;
			save_q    <= save_req;
			load_edge <= bk_load_cmd & ~load_q;
			save_edge <= save_req & ~save_q;
			ack_q     <= sd_ack;
			if (cram_wr & ~osd_open & has_save & save_enabled)
				save_pending <= 1'b1;
			else if (busy)
				save_pending <= 1'b0;
		end
	end

	////////////////////////////////////////
	// Block transfer FSM
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state   <= gb_ctrl_pkg::BK_IDLE;
			sd_q    <= '0;
			loading <= 1'b0;
		end else begin
			case (state)
				gb_ctrl_pkg::BK_IDLE: begin
					if (load_start | save_start) begin
						sd_q.lba <= '0;
						sd_q.rd  <= load_start;
						sd_q.wr  <= ~load_start;
						loading  <= load_start;
						state    <= gb_ctrl_pkg::BK_REQ;
					end
				end
				gb_ctrl_pkg::BK_REQ: begin
					if (sd_ack & ~ack_q) begin
						sd_q.rd <= 1'b0;
						sd_q.wr <= 1'b0;
						state   <= gb_ctrl_pkg::BK_WAIT_DONE;
					end
				end
				// Host drops ack once the block is through
				gb_ctrl_pkg::BK_WAIT_DONE: begin
					if (~sd_ack)
						state <= gb_ctrl_pkg::BK_NEXT;
				end
				gb_ctrl_pkg::BK_NEXT: begin
					if (last_block) begin
						loading <= 1'b0;
						state   <= gb_ctrl_pkg::BK_IDLE;
					end else begin
						sd_q.lba <= sd_q.lba + 32'd1;
						sd_q.rd  <= loading;
						sd_q.wr  <= ~loading;
						state    <= gb_ctrl_pkg::BK_REQ;
					end
				end
				default: state <= gb_ctrl_pkg::BK_IDLE;
			endcase
		end
	end

	assign sd   = sd_q;
	assign busy = (state != gb_ctrl_pkg::BK_IDLE);
	assign kind = (sd_q.lba[7:0] > ram_mask) ? gb_ctrl_pkg::BLK_RTC : gb_ctrl_pkg::BLK_RAM;

	a_rd_wr_excl : assert property (@(posedge clk_sys) disable iff (reset)
		!(sd.rd && sd.wr));

endmodule

// File: verilog/cheat_loader.sv
`timescale 1ns/1ps

module cheat_loader (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  gb_ctrl_pkg::dl_bus_t     dl,
	input  gb_ctrl_pkg::dl_target_e  target,
	output gb_ctrl_pkg::cheat_code_t code,
	output logic                     code_valid
);

	gb_ctrl_pkg::cheat_code_t code_q;
	logic                     cheat_wr;
	logic                     other_dl;

	assign cheat_wr = dl.wr && (target == gb_ctrl_pkg::DL_CHEAT);
	assign other_dl = (target == gb_ctrl_pkg::DL_CART) || (target == gb_ctrl_pkg::DL_PALETTE);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			code_q     <= '0;
			code_valid <= 1'b0;
		end else begin
			code_valid <= 1'b0;
			if (other_dl) begin
				code_q <= '0;
			end else if (cheat_wr) begin
				// First word of the file starts a fresh code list
				if (dl.addr == '0)
					code_q <= '0;
				// One code is 16 bytes, fields are low half first
				case (dl.addr[3:0])
					4'd0:  code_q.flags[15:0]    <= dl.data;
					4'd2:  code_q.flags[31:16]   <= dl.data;
					4'd4:  code_q.address[15:0]  <= dl.data;
					4'd6:  code_q.address[31:16] <= dl.data;
					4'd8:  code_q.compare[15:0]  <= dl.data;
					4'd10: code_q.compare[31:16] <= dl.data;
					4'd12: code_q.replace[15:0]  <= dl.data;
					4'd14: begin
						code_q.replace[31:16] <= dl.data;
						code_valid            <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	assign code = code_q;

	// Consecutive codes are at least one word write apart
	a_valid_single : assert property (@(posedge clk_sys) disable iff (reset)
		code_valid |=> !code_valid);

endmodule

// File: verilog/download_decoder.sv
`timescale 1ns/1ps

module download_decoder (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  gb_ctrl_pkg::dl_bus_t    dl,
	input  logic [7:0]              dl_index,
	input  logic                    img_mounted,
	input  logic                    img_readonly,
	output gb_ctrl_pkg::dl_target_e target,
	output logic                    cart_done,
	output logic                    save_enabled,
	output logic                    dl_active
);

	logic cart_now;
	logic cart_q;

	// Index to target, only while a download runs
	always_comb begin
		target = gb_ctrl_pkg::DL_NONE;
		if (dl.active) begin
			case (dl_index)
				gb_ctrl_pkg::FT_CART_GB,
				gb_ctrl_pkg::FT_CART_GBC,
				gb_ctrl_pkg::FT_CART_ALT: target = gb_ctrl_pkg::DL_CART;
				gb_ctrl_pkg::FT_PALETTE:  target = gb_ctrl_pkg::DL_PALETTE;
				gb_ctrl_pkg::FT_CHEAT:    target = gb_ctrl_pkg::DL_CHEAT;
				default:                  target = gb_ctrl_pkg::DL_NONE;
			endcase
		end
	end

	assign cart_now  = (target == gb_ctrl_pkg::DL_CART);
	assign dl_active = dl.active;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_q       <= 1'b0;
			cart_done    <= 1'b0;
			save_enabled <= 1'b0;
		end else begin
			cart_q    <= cart_now;
			cart_done <= cart_q & ~cart_now;

			// New cartridge forgets the previous save image
			if (cart_now & ~cart_q)
				save_enabled <= 1'b0;
			// The save image is mounted before the cart download ends
			if (cart_now & img_mounted & ~img_readonly)
				save_enabled <= 1'b1;
		end
	end

endmodule

// File: verilog/ff_control.sv
`timescale 1ns/1ps

module ff_control #(
	parameter int unsigned hold_cycles = 3200000
) (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        ff_button,
	input  logic        dl_active,
	input  logic        osd_open,
	input  logic        ff_mute_en,
	input  logic [15:0] audio_l,
	input  logic [15:0] audio_r,
	output logic        fast_forward,
	output logic [15:0] audio_l_out,
	output logic [15:0] audio_r_out
);

	localparam int cnt_w = $clog2(hold_cycles + 1);
	typedef logic [cnt_w-1:0] hold_cnt_t;

	logic      btn;
	logic      btn_q;
	logic      ff_latch;
	logic      was_latched;
	hold_cnt_t hold_cnt;

	// Button is ignored during downloads and with the menu up
	assign btn = ff_button & ~dl_active & ~osd_open;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			btn_q        <= 1'b0;
			ff_latch     <= 1'b0;
			was_latched  <= 1'b0;
			hold_cnt     <= '0;
			fast_forward <= 1'b0;
		end else begin
			btn_q <= btn;
			if (btn && hold_cnt < hold_cnt_t'(hold_cycles))
				hold_cnt <= hold_cnt + 1'b1;
			// Press
			if (btn & ~btn_q) begin
				ff_latch <= 1'b0;
				hold_cnt <= '0;
			end
			// Release, a short tap toggles the latch on every other tap
			if (~btn & btn_q) begin
				was_latched <= 1'b0;
				if (hold_cnt < hold_cnt_t'(hold_cycles) && !was_latched) begin
					was_latched <= 1'b1;
					ff_latch    <= 1'b1;
				end
			end
			fast_forward <= btn_q | ff_latch;
		end
	end

	assign audio_l_out = (fast_forward && ff_mute_en) ? 16'd0 : audio_l;
	assign audio_r_out = (fast_forward && ff_mute_en) ? 16'd0 : audio_r;

endmodule

// File: verilog/gb_ctrl_pkg.sv
package gb_ctrl_pkg;

	////////////////////////////////////////
	// Download port
	////////////////////////////////////////

	typedef logic [24:0] dl_addr_t;
	typedef logic [15:0] dl_word_t;

	typedef struct packed {
		logic     active;
		logic     wr;
		dl_addr_t addr;
		dl_word_t data;
	} dl_bus_t;

	typedef enum logic [1:0] {
		DL_NONE,
		DL_CART,
		DL_PALETTE,
		DL_CHEAT
	} dl_target_e;

	// File index values sent by the host
	localparam logic [7:0] FT_CART_GB  = 8'h01;
	localparam logic [7:0] FT_CART_GBC = 8'h41;
	localparam logic [7:0] FT_CART_ALT = 8'h80;
	localparam logic [7:0] FT_PALETTE  = 8'd3;
	localparam logic [7:0] FT_CHEAT    = 8'hff;

	////////////////////////////////////////
	// Palette and cheats
	////////////////////////////////////////

	typedef logic [23:0] color_t;

	// Color 1 sits in the top bits
	typedef struct packed {
		color_t c1;
		color_t c2;
		color_t c3;
		color_t c4;
	} palette_t;

	localparam logic [127:0] PALETTE_DEFAULT = 128'h8282_1451_7356_305a_5f1a_3b49_0000_0000;

	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	////////////////////////////////////////
	// SD image and backup RAM
	////////////////////////////////////////

	typedef logic [31:0] sd_lba_t;
	typedef logic [7:0]  buff_addr_t;
	typedef logic [16:0] bk_addr_t;

	typedef struct packed {
		sd_lba_t lba;
		logic    rd;
		logic    wr;
	} sd_req_t;

	typedef struct packed {
		bk_addr_t addr;
		dl_word_t data;
		logic     wr;
	} bk_bus_t;

	typedef enum logic {
		BLK_RAM,
		BLK_RTC
	} block_kind_e;

	typedef struct packed {
		logic [31:0] timestamp;
		logic [31:0] savedtime;
	} rtc_words_t;

	typedef enum logic [1:0] {
		BK_IDLE,
		BK_REQ,
		BK_WAIT_DONE,
		BK_NEXT
	} backup_state_e;

	// Read-back value for RTC block words past the time fields
	localparam dl_word_t RTC_FILL = 16'hffff;

endpackage

// File: verilog/gb_ctrl_top.sv
`timescale 1ns/1ps

module gb_ctrl_top #(
	parameter int unsigned ff_hold_cycles = 3200000
) (
	input  logic                     clk_sys,
	input  logic                     reset,
	// Host download and image
	input  gb_ctrl_pkg::dl_bus_t     dl,
	input  logic [7:0]               dl_index,
	input  logic                     img_mounted,
	input  logic                     img_readonly,
	input  logic                     img_size_nz,
	// Menu and cart status
	input  logic                     bk_load_cmd,
	input  logic                     bk_save_cmd,
	input  logic                     autosave,
	input  logic                     osd_open,
	input  logic                     cram_wr,
	input  logic                     has_save,
	input  logic [7:0]               ram_mask,
	input  logic                     rtc_inuse,
	input  gb_ctrl_pkg::rtc_words_t  rtc,
	input  gb_ctrl_pkg::dl_word_t    bk_q,
	// SD block buffer
	input  logic                     sd_ack,
	input  gb_ctrl_pkg::buff_addr_t  sd_buff_addr,
	input  gb_ctrl_pkg::dl_word_t    sd_buff_dout,
	input  logic                     sd_buff_wr,
	// Fast forward and audio
	input  logic                     ff_button,
	input  logic                     ff_mute_en,
	input  logic [15:0]              audio_l,
	input  logic [15:0]              audio_r,
	output gb_ctrl_pkg::palette_t    palette,
	output gb_ctrl_pkg::cheat_code_t code,
	output logic                     code_valid,
	output logic                     fast_forward,
	output logic [15:0]              audio_l_out,
	output logic [15:0]              audio_r_out,
	output gb_ctrl_pkg::sd_req_t     sd,
	output gb_ctrl_pkg::bk_bus_t     bk,
	output logic                     rtc_wr,
	output gb_ctrl_pkg::dl_word_t    sd_buff_din,
	output logic                     busy,
	output logic                     led_user
);

	gb_ctrl_pkg::dl_target_e  target;
	gb_ctrl_pkg::block_kind_e kind;
	logic                     cart_done;
	logic                     save_enabled;
	logic                     dl_active;
	logic                     save_pending;

	download_decoder i_download_decoder (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl           (dl),
		.dl_index     (dl_index),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.target       (target),
		.cart_done    (cart_done),
		.save_enabled (save_enabled),
		.dl_active    (dl_active)
	);

	palette_store i_palette_store (
		.clk_sys (clk_sys),
		.reset   (reset),
		.dl      (dl),
		.target  (target),
		.palette (palette)
	);

	cheat_loader i_cheat_loader (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl         (dl),
		.target     (target),
		.code       (code),
		.code_valid (code_valid)
	);

	ff_control #(
		.hold_cycles (ff_hold_cycles)
	) i_ff_control (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.ff_button    (ff_button),
		.dl_active    (dl_active),
		.osd_open     (osd_open),
		.ff_mute_en   (ff_mute_en),
		.audio_l      (audio_l),
		.audio_r      (audio_r),
		.fast_forward (fast_forward),
		.audio_l_out  (audio_l_out),
		.audio_r_out  (audio_r_out)
	);

	backup_sequencer i_backup_sequencer (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cart_done    (cart_done),
		.save_enabled (save_enabled),
		.has_save     (has_save),
		.img_size_nz  (img_size_nz),
		.bk_load_cmd  (bk_load_cmd),
		.bk_save_cmd  (bk_save_cmd),
		.autosave     (autosave),
		.osd_open     (osd_open),
		.cram_wr      (cram_wr),
		.ram_mask     (ram_mask),
		.rtc_inuse    (rtc_inuse),
		.sd_ack       (sd_ack),
		.sd           (sd),
		.kind         (kind),
		.busy         (busy),
		.save_pending (save_pending)
	);

	backup_port i_backup_port (
		.kind         (kind),
		.lba_low      (sd.lba[7:0]),
		.sd_ack       (sd_ack),
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_dout (sd_buff_dout),
		.sd_buff_wr   (sd_buff_wr),
		.bk_q         (bk_q),
		.rtc          (rtc),
		.bk           (bk),
		.rtc_wr       (rtc_wr),
		.sd_buff_din  (sd_buff_din)
	);

	// Lit while loading or with unsaved cart RAM
	assign led_user = dl_active | save_pending;

endmodule

// File: verilog/palette_store.sv
`timescale 1ns/1ps

module palette_store (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  gb_ctrl_pkg::dl_bus_t    dl,
	input  gb_ctrl_pkg::dl_target_e target,
	output gb_ctrl_pkg::palette_t   palette
);

	logic [127:0] palette_q;
	logic         pal_wr;

	assign pal_wr = dl.wr && (target == gb_ctrl_pkg::DL_PALETTE);

	// Palette file holds big-endian bytes, the download word is little-endian
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			palette_q <= gb_ctrl_pkg::PALETTE_DEFAULT;
		end else if (pal_wr) begin
			palette_q <= {palette_q[111:0], dl.data[7:0], dl.data[15:8]};
		end
	end

	// Low 32 bits are padding in the file
	assign palette = palette_q[127:32];

endmodule
